// File: include/fm_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register front end, global sizing
// channel count, busy length and prescaler divide out of reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FM_DEFINES_SVH
`define FM_DEFINES_SVH

// two banks of three channels
`define FM_NCH 6

// busy length in clk_en ticks, as on the real chip
`define FM_BUSY_TICKS 32

// prescaler divide after reset, same as a 0x2D write
`define FM_DIV_RESET 6

`endif

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_fm_core_regs -o sim_tb

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
	cat sim.log
	echo "simulator exited with an error"
	exit 1
fi
cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

// File: verif/tb_fm_core_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM core register front end testbench
// host writes through the 2 bit port, a reference model of the six
// channels, slot readout checks, busy and prescaler timing checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fm_defines.svh"

module tb_fm_core_regs;
	import fm_chan_pkg::*;

	localparam int CLK_NS    = 40;
	localparam int N_TESTS   = 6;
	localparam int MAX_WR    = 20; // data writes in the longest test
	localparam int SCAN_CLKS = `FM_NCH * `FM_DIV_RESET;
	localparam int BUSY_CLKS = `FM_BUSY_TICKS * `FM_DIV_RESET;
	localparam longint WD_NS = longint'(N_TESTS) * (MAX_WR * (BUSY_CLKS + 16) + 4 * SCAN_CLKS)
		* CLK_NS * 2; // double for margin

	logic       clk = 1'b0;
	logic       rst;
	logic [1:0] addr;
	logic [7:0] din;
	logic       write;
	logic       busy;
	logic       clk_en;
	logic       slot_valid;
	chan_idx_t  slot_ch;
	fnum_t      slot_fnum;
	block_t     slot_block;
	alg_t       slot_alg;
	fb_t        slot_fb;
	logic       slot_keyon;

	// expected channel contents
	fnum_t      exp_fnum  [`FM_NCH];
	block_t     exp_block [`FM_NCH];
	alg_t       exp_alg   [`FM_NCH];
	fb_t        exp_fb    [`FM_NCH];
	logic       exp_keyon [`FM_NCH];
	logic [5:0] exp_hi;   // model of the shared high latch
	chan_idx_t  next_ch;  // scan order tracker

	int seed = 53510;
	int err_count = 0;
	int test_err_start = 0;
	int tests_run = 0;
	int tests_failed = 0;

	fm_core_regs UUT (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.addr       ( addr       ),
		.din        ( din        ),
		.write      ( write      ),
		.busy       ( busy       ),
		.clk_en     ( clk_en     ),
		.slot_valid ( slot_valid ),
		.slot_ch    ( slot_ch    ),
		.slot_fnum  ( slot_fnum  ),
		.slot_block ( slot_block ),
		.slot_alg   ( slot_alg   ),
		.slot_fb    ( slot_fb    ),
		.slot_keyon ( slot_keyon )
	);

	always #20 clk = ~clk; // 40 ns period

	function automatic void note_mismatch(input string sig, input int unsigned want,
		input int unsigned got);
		$display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, want, got);
		err_count++;
	endfunction

	function automatic void note_failure(input string msg);
		$display("check failed at %0t ns: %s", $time, msg);
		err_count++;
	endfunction

	// register map rules applied to the expected channel set
	function automatic void model_write(input logic bank, input logic [7:0] r,
		input logic [7:0] d);
		chan_idx_t ch;
		ch = chan_idx_t'(3 * int'(bank) + int'(r[1:0]));
		if (r == 8'h28) begin
			if (d[1:0] != 2'd3)
				exp_keyon[chan_idx_t'(3 * int'(d[2]) + int'(d[1:0]))] = |d[7:4];
		end else if (r[1:0] != 2'd3) begin
			if (r >= 8'hA4 && r <= 8'hA6) begin
				exp_hi = d[5:0]; // one latch for all channels
			end else if (r >= 8'hA0 && r <= 8'hA2) begin
				exp_fnum[ch]  = {exp_hi[2:0], d};
				exp_block[ch] = exp_hi[5:3];
			end else if (r >= 8'hB0 && r <= 8'hB2) begin
				exp_fb[ch]  = d[5:3];
				exp_alg[ch] = d[2:0];
			end
		end
	endfunction

	task automatic align();
		@(posedge clk);
		#1;
	endtask

	// one write edge with write high for a cycle then low for a cycle
	task automatic host_write(input logic [1:0] a, input logic [7:0] d);
		addr  = a;
		din   = d;
		write = 1'b1;
		@(posedge clk);
		#1 write = 1'b0;
		align();
	endtask

	task automatic wait_not_busy();
		while (busy)
			align();
	endtask

	// register number then data
	// model steps right after the first scanner sample of the new slice value
	task automatic reg_write(input logic bank, input logic [7:0] r, input logic [7:0] d);
		host_write({bank, 1'b0}, r);
		wait_not_busy();
		host_write({bank, 1'b1}, d);
		@(posedge clk);
		#1 model_write(bank, r, d);
	endtask

	task automatic wait_slot(input chan_idx_t ch);
		@(negedge clk);
		while (!(slot_valid && slot_ch == ch))
			@(negedge clk);
		align();
	endtask

	task automatic wait_all_slots();
		repeat (`FM_NCH + 1) begin
			@(negedge clk);
			while (!slot_valid)
				@(negedge clk);
		end
		align();
	endtask

	task automatic count_busy_ticks(output int ticks);
		bit seen;
		bit done;
		ticks = 0;
		seen  = 1'b0;
		done  = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (busy) begin
				seen = 1'b1;
				if (clk_en)
					ticks++;
			end else if (seen) begin
				done = 1'b1;
			end
		end
	endtask

	task automatic check_spacing(input int want);
		int gap;
		// skip pulses until the new divide has landed at a counter wrap
		repeat (3) begin
			@(negedge clk);
			while (!clk_en)
				@(negedge clk);
		end
		for (int k = 0; k < 4; k++) begin
			gap = 0;
			@(negedge clk);
			gap++;
			while (!clk_en) begin
				@(negedge clk);
				gap++;
			end
			assert (gap == want) else note_mismatch("clk_en spacing", want, gap);
		end
		align();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_count == test_err_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", tests_run, name,
				err_count - test_err_start);
		end
		test_err_start = err_count;
	endtask

	// one property per slot field against the model
	a_fnum: assert property (@(posedge clk) disable iff (rst)
		slot_valid |-> slot_fnum == exp_fnum[slot_ch])
		else note_mismatch("slot_fnum", 32'(exp_fnum[$sampled(slot_ch)]),
			32'($sampled(slot_fnum)));
	a_block: assert property (@(posedge clk) disable iff (rst)
		slot_valid |-> slot_block == exp_block[slot_ch])
		else note_mismatch("slot_block", 32'(exp_block[$sampled(slot_ch)]),
			32'($sampled(slot_block)));
	a_alg: assert property (@(posedge clk) disable iff (rst)
		slot_valid |-> slot_alg == exp_alg[slot_ch])
		else note_mismatch("slot_alg", 32'(exp_alg[$sampled(slot_ch)]),
			32'($sampled(slot_alg)));
	a_fb: assert property (@(posedge clk) disable iff (rst)
		slot_valid |-> slot_fb == exp_fb[slot_ch])
		else note_mismatch("slot_fb", 32'(exp_fb[$sampled(slot_ch)]), 32'($sampled(slot_fb)));
	a_keyon: assert property (@(posedge clk) disable iff (rst)
		slot_valid |-> slot_keyon == exp_keyon[slot_ch])
		else note_mismatch("slot_keyon", 32'(exp_keyon[$sampled(slot_ch)]),
			32'($sampled(slot_keyon)));

	// scan order check starting from channel 0 after reset
	always @(negedge clk) begin
		if (rst) begin
			next_ch = '0;
		end else if (slot_valid) begin
			assert (slot_ch == next_ch)
				else note_mismatch("slot_ch", 32'(next_ch), 32'(slot_ch));
			next_ch = (slot_ch == chan_idx_t'(`FM_NCH - 1)) ? '0 : slot_ch + 3'd1;
		end
	end

	initial begin
		#(WD_NS);
		$display("watchdog expired after %0d ns, tests did not finish", WD_NS);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic       bank;
		logic [7:0] rnd;
		int         ticks;
		rst   = 1'b1;
		addr  = 2'd0;
		din   = 8'd0;
		write = 1'b0;
		exp_hi = '0;
		for (int c = 0; c < `FM_NCH; c++) begin
			exp_fnum[c]  = '0;
			exp_block[c] = '0;
			exp_alg[c]   = '0;
			exp_fb[c]    = '0;
			exp_keyon[c] = 1'b0;
		end

		// reset state
		@(posedge clk);
		@(negedge clk);
		assert (busy == 1'b0) else note_mismatch("busy", 0, 32'(busy));
		assert (clk_en == 1'b0) else note_mismatch("clk_en", 0, 32'(clk_en));
		assert (slot_valid == 1'b0) else note_mismatch("slot_valid", 0, 32'(slot_valid));
		assert (slot_fnum == '0) else note_mismatch("slot_fnum", 0, 32'(slot_fnum));
		assert (slot_block == '0 && slot_alg == '0 && slot_fb == '0 && !slot_keyon)
			else note_failure("slot parameters not cleared by reset");
		@(posedge clk);
		#1 rst = 1'b0;
		wait_all_slots();
		end_test("reset state");

		// frequency writes in both banks then the shared latch across channels
		for (int c = 0; c < `FM_NCH; c++) begin
			bank = (c >= 3);
			rnd  = 8'($random(seed));
			reg_write(bank, 8'hA4 + 8'(c % 3), rnd & 8'h3F);
			rnd  = 8'($random(seed));
			reg_write(bank, 8'hA0 + 8'(c % 3), rnd);
			wait_slot(chan_idx_t'(c));
		end
		reg_write(1'b0, 8'hA5, 8'h2B); // latch via channel 1 registers
		reg_write(1'b1, 8'hA2, 8'h5C); // lands on channel 5
		wait_slot(3'd5);
		end_test("frequency writes");

		// feedback and algorithm then the holes at low bits 3
		for (int c = 0; c < `FM_NCH; c++) begin
			rnd = 8'($random(seed));
			reg_write(c >= 3, 8'hB0 + 8'(c % 3), rnd);
		end
		reg_write(1'b0, 8'hB3, 8'h3F);
		reg_write(1'b1, 8'hB3, 8'h2D);
		reg_write(1'b0, 8'hA3, 8'hFF);
		reg_write(1'b1, 8'hA7, 8'h3F);
		reg_write(1'b0, 8'hA1, 8'h00); // shows the latch untouched by 0xA7
		wait_all_slots();
		end_test("algorithm and feedback");

		// key-on set for every code then cleared
		for (int code = 0; code < 8; code++) begin
			rnd = 8'($random(seed));
			reg_write(1'b0, 8'h28, (rnd & 8'hF0) | 8'h10 | 8'(code));
			wait_all_slots();
		end
		for (int code = 0; code < 8; code++) begin
			reg_write(1'b0, 8'h28, 8'(code));
			wait_all_slots();
		end
		end_test("key-on");

		// busy length on an operator register that no channel holds
		host_write(2'b00, 8'h30);
		wait_not_busy();
		fork
			begin
				host_write(2'b01, 8'h11);
				assert (busy) else note_failure("busy stayed low after a data write");
			end
			count_busy_ticks(ticks);
		join
		assert (ticks == `FM_BUSY_TICKS) else note_mismatch("busy clk_en count",
			`FM_BUSY_TICKS, ticks);
		align();
		host_write(2'b00, 8'hB0);
		repeat (8) begin
			@(negedge clk);
			assert (!busy) else note_mismatch("busy", 0, 32'(busy));
		end
		align();
		end_test("busy timing");

		// prescaler select with divide 2 and 3 then back to 6
		reg_write(1'b0, 8'h2F, 8'h00);
		check_spacing(2);
		reg_write(1'b0, 8'h2E, 8'h00);
		check_spacing(3);
		reg_write(1'b0, 8'h2D, 8'h00);
		check_spacing(6);
		wait_all_slots();
		end_test("prescaler");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: verilog/fm_chan_par_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM channel parameter bus
// static register contents of one channel, slice to scanner
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface fm_chan_par_if;
	import fm_chan_pkg::*;

	// plain register values, sampled whenever the scanner likes
	fnum_t  fnum;
	block_t block;
	alg_t   alg;
	fb_t    fb;
	logic   keyon; // any operator keyed

	modport src (
		output fnum, block, alg, fb, keyon
	);

	modport dst (
		input fnum, block, alg, fb, keyon
	);

endinterface

// File: verilog/fm_chan_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register front end, channel parameter types
// widths of the per channel values held in the slices
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fm_chan_pkg;

	// 0..2 lower bank, 3..5 upper bank
	typedef logic [2:0] chan_idx_t;

	// phase increment, low byte plus 3 bits from the latch
	typedef logic [10:0] fnum_t;

	// octave
	typedef logic [2:0] block_t;

	// operator connection
	typedef logic [2:0] alg_t;

	// op1 self feedback depth
	typedef logic [2:0] fb_t;

endpackage

// File: verilog/fm_chan_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM channel register slice
// holds fnum, block, algorithm, feedback and key-on of one channel
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fm_defines.svh"

module fm_chan_regs #(
	parameter fm_chan_pkg::chan_idx_t CH_INDEX = '0
) (
	input  logic       clk,
	input  logic       rst,
	fm_chan_wr_if.dst  wr,
	fm_chan_par_if.src par
);
	import fm_reg_pkg::*;
	import fm_chan_pkg::*;

	fnum_t  fnum_q;
	block_t block_q;
	alg_t   alg_q;
	fb_t    fb_q;
	logic   keyon_q;
	logic   hit;

	// every slice sees the write, only the addressed one takes it
	assign hit = wr.wr_valid && (wr.wr_ch == CH_INDEX);

	always_ff @(posedge clk) begin
		if (rst) begin
			fnum_q  <= '0;
			block_q <= '0;
			alg_q   <= '0;
			fb_q    <= '0;
			keyon_q <= 1'b0;
		end else if (hit) begin
			case (wr.wr_field)
				FLD_FNUM: {block_q, fnum_q} <= {wr.wr_hi, wr.wr_data}; // latch + low byte
				FLD_FBALG: begin
					fb_q  <= wr.wr_data[5:3];
					alg_q <= wr.wr_data[2:0];
				end
				FLD_KEYON: keyon_q <= wr.wr_data[0];
				default: ;
			endcase
		end
	end

	assign par.fnum  = fnum_q;
	assign par.block = block_q;
	assign par.alg   = alg_q;
	assign par.fb    = fb_q;
	assign par.keyon = keyon_q;

	// decoder drops key-on codes 3 and 7, so no key-on names a missing channel
	a_keyon_ch: assert property (@(posedge clk) disable iff (rst)
		(wr.wr_valid && wr.wr_field == FLD_KEYON) |-> (wr.wr_ch < chan_idx_t'(`FM_NCH)));

endmodule

// File: verilog/fm_chan_wr_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM decoded channel write bus
// one write pulse from the register decoder, broadcast to every slice
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface fm_chan_wr_if;
	import fm_reg_pkg::*;
	import fm_chan_pkg::*;

	logic      wr_valid; // one cycle pulse
	chan_idx_t wr_ch;    // target channel, compared in the slice
	field_t    wr_field;
	logic [7:0] wr_data; // raw byte, key bit in bit 0 for key-on
	logic [5:0] wr_hi;   // shared latch, block and fnum[10:8]

	modport src (
		output wr_valid, wr_ch, wr_field, wr_data, wr_hi
	);

	modport dst (
		input wr_valid, wr_ch, wr_field, wr_data, wr_hi
	);

endinterface

// File: verilog/fm_core_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM core register front end, top level
// host decoder, six channel slices and the slot scanner
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fm_defines.svh"

module fm_core_regs (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [1:0]              addr,  // bit0 data, bit1 upper bank
	input  logic [7:0]              din,
	input  logic                    write,
	output logic                    busy,  // advisory only
	output logic                    clk_en,
	output logic                    slot_valid,
	output fm_chan_pkg::chan_idx_t  slot_ch,
	output fm_chan_pkg::fnum_t      slot_fnum,
	output fm_chan_pkg::block_t     slot_block,
	output fm_chan_pkg::alg_t       slot_alg,
	output fm_chan_pkg::fb_t        slot_fb,
	output logic                    slot_keyon
);
	import fm_chan_pkg::*;

	fm_chan_wr_if  wr_bus ();
	fm_chan_par_if par_bus [`FM_NCH] ();

	// key-on field bits are already folded into wr_data[0] by the decoder
	fm_mmr u_mmr (
		.clk    ( clk    ),
		.rst    ( rst    ),
		.addr   ( addr   ),
		.din    ( din    ),
		.write  ( write  ),
		.busy   ( busy   ),
		.clk_en ( clk_en ),
		.wr     ( wr_bus.src )
	);

	for (genvar g = 0; g < `FM_NCH; g++) begin : g_chan
		fm_chan_regs #(
			.CH_INDEX ( chan_idx_t'(g) )
		) u_chan (
			.clk ( clk ),
			.rst ( rst ),
			.wr  ( wr_bus.dst ),
			.par ( par_bus[g].src )
		);
	end

	fm_slot_scan u_scan (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.clk_en     ( clk_en     ),
		.chans      ( par_bus    ),
		.slot_valid ( slot_valid ),
		.slot_ch    ( slot_ch    ),
		.slot_fnum  ( slot_fnum  ),
		.slot_block ( slot_block ),
		.slot_alg   ( slot_alg   ),
		.slot_fb    ( slot_fb    ),
		.slot_keyon ( slot_keyon )
	);

endmodule

// File: verilog/fm_mmr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM memory mapped register decoder
// host port edge detect, register number latch, channel write decode,
// shared fnum high latch, clock prescaler and advisory busy timer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fm_defines.svh"

module fm_mmr (
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	input  logic       write,
	output logic       busy,
	output logic       clk_en,
	fm_chan_wr_if.src  wr
);
	import fm_reg_pkg::*;
	import fm_chan_pkg::*;

	localparam int BCW = $clog2(`FM_BUSY_TICKS);
	localparam logic [BCW-1:0] BUSY_LAST = BCW'(`FM_BUSY_TICKS - 1);
	localparam logic [2:0] DIV_RST_LIM = 3'(`FM_DIV_RESET - 1);

	logic           old_write;
	logic           wr_edge;
	reg_num_t       reg_num;
	logic [5:0]     fnum_hi;   // single latch shared by all channels
	logic           hi_load;
	logic           dec_valid;
	field_t         dec_field;
	chan_idx_t      dec_ch;
	logic [7:0]     dec_data;
	logic           div_load;
	logic [2:0]     div_val;
	logic [2:0]     div_nxt;   // requested limit, applied on wrap
	logic [2:0]     div_lim;
	logic [2:0]     pre_cnt;
	busy_state_t    bstate;
	logic [BCW-1:0] busy_cnt;

	// upper bank starts at channel 3
	function automatic chan_idx_t chan_sel(input logic bank, input logic [1:0] lo);
		chan_idx_t base;
		base = bank ? 3'd3 : 3'd0;
		return base + {1'b0, lo};
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			old_write <= 1'b0;
		else
			old_write <= write;
	end

	assign wr_edge = write & ~old_write; // rising edge only

	// even address picks the register
	always_ff @(posedge clk) begin
		if (rst)
			reg_num <= '0;
		else if (wr_edge && !addr[0])
			reg_num <= din;
	end

	// data write decode
	always_comb begin
		dec_valid = 1'b0;
		dec_field = FLD_FNUM;
		dec_ch    = chan_sel(addr[1], reg_num[1:0]); // bank from addr bit 1
		dec_data  = din;
		hi_load   = 1'b0;
		div_load  = 1'b0;
		div_val   = div_nxt;
		if (wr_edge && addr[0]) begin
			if (reg_num == REG_KEYON) begin
				// channel code lives in din, codes 3 and 7 are holes
				dec_valid = din[1:0] != 2'd3;
				dec_field = FLD_KEYON;
				dec_ch    = chan_sel(din[2], din[1:0]);
				dec_data  = {7'd0, |din[7:4]}; // any operator bit keys the channel
			end else if (reg_num[1:0] != 2'd3) begin
				case (reg_num[7:2])
					REG_FNUM_LO[7:2]: dec_valid = 1'b1;
					REG_FNUM_HI[7:2]: hi_load = 1'b1; // no channel write yet
					REG_FBALG[7:2]: begin
						dec_valid = 1'b1;
						dec_field = FLD_FBALG;
					end
					default: ;
				endcase
			end
			case (reg_num)
				REG_DIV6: begin
					div_load = 1'b1;
					div_val  = 3'd5;
				end
				REG_DIV3: begin
					div_load = 1'b1;
					div_val  = 3'd2;
				end
				REG_DIV2: begin
					div_load = 1'b1;
					div_val  = 3'd1;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			fnum_hi <= '0;
		else if (hi_load)
			fnum_hi <= din[5:0]; // block in 5:3, fnum[10:8] in 2:0
	end

	// write pulse, one cycle after the edge
	always_ff @(posedge clk) begin
		if (rst)
			wr.wr_valid <= 1'b0;
		else
			wr.wr_valid <= dec_valid;
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			wr.wr_ch    <= dec_ch;
			wr.wr_field <= dec_field;
			wr.wr_data  <= dec_data;
		end
	end

	assign wr.wr_hi = fnum_hi; // latch value at the time of the low write

	// prescaler, clk_en every div_lim+1 clocks
	always_ff @(posedge clk) begin
		if (rst) begin
			pre_cnt <= '0;
			div_lim <= DIV_RST_LIM;
			div_nxt <= DIV_RST_LIM;
			clk_en  <= 1'b0;
		end else begin
			if (div_load)
				div_nxt <= div_val;
			clk_en <= pre_cnt == div_lim;
			if (pre_cnt == div_lim) begin
				pre_cnt <= '0;
				div_lim <= div_nxt; // new divide only at wrap
			end else begin
				pre_cnt <= pre_cnt + 3'd1;
			end
		end
	end

	// busy FSM, restarts on every data write, address writes leave it alone
	always_ff @(posedge clk) begin
		if (rst) begin
			bstate   <= BUSY_IDLE;
			busy     <= 1'b0;
			busy_cnt <= '0;
		end else if (wr_edge && addr[0]) begin
			bstate   <= BUSY_ACTIVE;
			busy     <= 1'b1;
			busy_cnt <= '0;
		end else if (clk_en) begin
			case (bstate)
				BUSY_ACTIVE: begin
					if (busy_cnt == BUSY_LAST) begin
						bstate <= BUSY_IDLE; // 32nd tick
						busy   <= 1'b0;
					end else begin
						busy_cnt <= busy_cnt + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	// host edges are at least two clocks apart
	a_wr_pulse: assert property (@(posedge clk) disable iff (rst)
		wr.wr_valid |=> !wr.wr_valid);

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		(bstate == BUSY_IDLE) |-> !busy);

endmodule

// File: verilog/fm_reg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register front end, host side types
// register numbers, channel field select and busy FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fm_reg_pkg;

	typedef logic [7:0] reg_num_t; // latched on even address writes
	typedef logic [1:0] field_t;   // which channel field a write hits

	// channel field codes, 0 never sent
	localparam field_t FLD_KEYON = 2'd1;
	localparam field_t FLD_FNUM  = 2'd2;
	localparam field_t FLD_FBALG = 2'd3;

	// global registers
	localparam reg_num_t REG_KEYON = 8'h28;
	localparam reg_num_t REG_DIV6  = 8'h2D;
	localparam reg_num_t REG_DIV3  = 8'h2E;
	localparam reg_num_t REG_DIV2  = 8'h2F;

	// per channel register groups, low two bits pick the channel
	localparam reg_num_t REG_FNUM_LO = 8'hA0;
	localparam reg_num_t REG_FNUM_HI = 8'hA4; // goes to the shared latch
	localparam reg_num_t REG_FBALG   = 8'hB0;

	typedef enum logic {
		BUSY_IDLE,
		BUSY_ACTIVE
	} busy_state_t;

endpackage

// File: verilog/fm_slot_scan.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM slot scanner
// round robin readout of the channel slices, one channel per clk_en
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fm_defines.svh"

module fm_slot_scan (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    clk_en,
	fm_chan_par_if.dst              chans [`FM_NCH],
	output logic                    slot_valid,
	output fm_chan_pkg::chan_idx_t  slot_ch,
	output fm_chan_pkg::fnum_t      slot_fnum,
	output fm_chan_pkg::block_t     slot_block,
	output fm_chan_pkg::alg_t       slot_alg,
	output fm_chan_pkg::fb_t        slot_fb,
	output logic                    slot_keyon
);
	import fm_chan_pkg::*;

	chan_idx_t ptr; // channel read on the next clk_en
	fnum_t     fnum_a  [`FM_NCH];
	block_t    block_a [`FM_NCH];
	alg_t      alg_a   [`FM_NCH];
	fb_t       fb_a    [`FM_NCH];
	logic      keyon_a [`FM_NCH];

	// flatten the interface array so the pointer can index it
	for (genvar g = 0; g < `FM_NCH; g++) begin : g_flat
		assign fnum_a[g]  = chans[g].fnum;
		assign block_a[g] = chans[g].block;
		assign alg_a[g]   = chans[g].alg;
		assign fb_a[g]    = chans[g].fb;
		assign keyon_a[g] = chans[g].keyon;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr        <= '0;
			slot_valid <= 1'b0;
			slot_ch    <= '0;
			slot_fnum  <= '0;
			slot_block <= '0;
			slot_alg   <= '0;
			slot_fb    <= '0;
			slot_keyon <= 1'b0;
		end else begin
			slot_valid <= clk_en;
			if (clk_en) begin
				slot_ch    <= ptr;
				slot_fnum  <= fnum_a[ptr];
				slot_block <= block_a[ptr];
				slot_alg   <= alg_a[ptr];
				slot_fb    <= fb_a[ptr];
				slot_keyon <= keyon_a[ptr];
				ptr <= (ptr == chan_idx_t'(`FM_NCH - 1)) ? '0 : ptr + 3'd1; // wrap after ch5
			end
		end
	end

	a_slot_after_cen: assert property (@(posedge clk) disable iff (rst)
		slot_valid |-> $past(clk_en));

endmodule

// File: vlog.f
+incdir+include
verilog/fm_reg_pkg.sv
verilog/fm_chan_pkg.sv
verilog/fm_chan_wr_if.sv
verilog/fm_chan_par_if.sv
verilog/fm_mmr.sv
verilog/fm_chan_regs.sv
verilog/fm_slot_scan.sv
verilog/fm_core_regs.sv
verif/tb_fm_core_regs.sv
